// ==== verilog/stopwatch_pkg.sv ====
package stopwatch_pkg;

   // One BCD digit and one active-low segment vector (bit 0 is segment a)
   typedef logic [3:0] bcd_t;
   typedef logic [6:0] seg_t;

   localparam seg_t SEG_BLANK = 7'h7f;

   // Digit limits of the mm:ss fields
   localparam bcd_t UNITS_MAX    = 4'd9;
   localparam bcd_t SEC_TENS_MAX = 4'd5;
   localparam bcd_t MIN_TENS_MAX = 4'd5;

   // Meaning of the sel switch level
   localparam logic SEL_MINUTES = 1'b0;
   localparam logic SEL_SECONDS = 1'b1;

   //////////////////////////////////////////////////////////////////////
   // Digit to segment table, common anode so a lit segment is 0
   function automatic seg_t bcd_to_seg(input bcd_t value);
      seg_t pattern;
      case (value)
         4'd0:    pattern = 7'h40;
         4'd1:    pattern = 7'h79;
         4'd2:    pattern = 7'h24;
         4'd3:    pattern = 7'h30;
         4'd4:    pattern = 7'h19;
         4'd5:    pattern = 7'h12;
         4'd6:    pattern = 7'h02;
         4'd7:    pattern = 7'h78;
         4'd8:    pattern = 7'h00;
         4'd9:    pattern = 7'h10;
         // Codes above 9 never occur in a valid time
         default: pattern = SEG_BLANK;
      endcase
      return pattern;
   endfunction

endpackage

// ==== verilog/time_if.sv ====
`timescale 1ns/1ns

// Four BCD digits of the running time, timer to display
interface time_if;

   import stopwatch_pkg::*;

   // Seconds
   bcd_t units;
   bcd_t tens;

   // Minutes
   bcd_t hundreds;
   bcd_t thousands;

   // Timer owns the digits
   modport timer (
      output units,
      output tens,
      output hundreds,
      output thousands
   );

   // Display only reads them
   modport disp (
      input units,
      input tens,
      input hundreds,
      input thousands
   );

endinterface

// ==== verilog/tick_gen.sv ====
`timescale 1ns/1ns

module tick_gen #(
   parameter int DIV_1HZ  = 100_000_000,
   parameter int DIV_SCAN = 100_000
) (
   input  logic clk,
   input  logic rst_n,
   input  logic restart,
   output logic tick_1hz,
   output logic tick_2hz,
   output logic tick_scan,
   output logic blink
);

   localparam int HALF   = DIV_1HZ / 2;
   localparam int HALF_W = (HALF > 1) ? $clog2(HALF) : 1;
   localparam int SCAN_W = (DIV_SCAN > 1) ? $clog2(DIV_SCAN) : 1;

   logic [HALF_W-1:0] half_cnt;
   logic [SCAN_W-1:0] scan_cnt;
   logic              half_wrap;
   logic              scan_wrap;

   assign half_wrap = (half_cnt == HALF_W'(HALF - 1));
   assign scan_wrap = (scan_cnt == SCAN_W'(DIV_SCAN - 1));

   //////////////////////////////////////////////////////////////////////
   // Half-second chain, blink doubles as the second phase
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         half_cnt <= '0;
         blink    <= 1'b0;
         tick_2hz <= 1'b0;
         tick_1hz <= 1'b0;
      end else if (restart) begin
         half_cnt <= '0;
         blink    <= 1'b0;
         tick_2hz <= 1'b0;
         tick_1hz <= 1'b0;
      end else begin
         half_cnt <= half_wrap ? '0 : half_cnt + 1'b1;
         tick_2hz <= half_wrap;
         // Every second half-second tick closes a full second
         tick_1hz <= half_wrap & blink;
         if (half_wrap)
            blink <= ~blink;
      end
   end

   // Digit scan rate
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         scan_cnt  <= '0;
         tick_scan <= 1'b0;
      end else if (restart) begin
         scan_cnt  <= '0;
         tick_scan <= 1'b0;
      end else begin
         scan_cnt  <= scan_wrap ? '0 : scan_cnt + 1'b1;
         tick_scan <= scan_wrap;
      end
   end

endmodule

// ==== verilog/debouncer.sv ====
`timescale 1ns/1ns

module debouncer #(
   parameter int DEBOUNCE_CYCLES = 1_000_000
) (
   input  logic clk,
   input  logic rst_n,
   input  logic switch_input,
   output logic state,
   output logic press
);

   localparam int CNT_W = (DEBOUNCE_CYCLES > 1) ? $clog2(DEBOUNCE_CYCLES) : 1;

   logic             sync_1;
   logic             sync_2;
   logic [CNT_W-1:0] stable_cnt;
   logic             at_limit;

   //////////////////////////////////////////////////////////////////////
   // Two-flop synchronizer for the raw board input
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sync_1 <= 1'b0;
         sync_2 <= 1'b0;
      end else begin
         sync_1 <= switch_input;
         sync_2 <= sync_1;
      end
   end

   assign at_limit = (stable_cnt == CNT_W'(DEBOUNCE_CYCLES - 1));

   //////////////////////////////////////////////////////////////////////
   // Stability counter
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         stable_cnt <= '0;
         state      <= 1'b0;
         press      <= 1'b0;
      end else begin
         press <= 1'b0;
         if (sync_2 == state) begin
            // Input agrees with state, any bounce so far is forgotten
            stable_cnt <= '0;
         end else if (at_limit) begin
            stable_cnt <= '0;
            state      <= sync_2;
            // Pulse in the same cycle that state goes high
            press      <= sync_2;
         end else begin
            stable_cnt <= stable_cnt + 1'b1;
         end
      end
   end

endmodule

// ==== verilog/timer_seq.sv ====
`timescale 1ns/1ns

module timer_seq (
   input  logic clk,
   input  logic rst_n,
   input  logic tick_1hz,
   input  logic tick_2hz,
   input  logic reset,
   input  logic pause,
   input  logic sel,
   input  logic adj,
   time_if.timer time_o
);

   import stopwatch_pkg::*;

   bcd_t units_q;
   bcd_t tens_q;
   bcd_t hundreds_q;
   bcd_t thousands_q;
   logic run_q;

   // {carry, tens, units} of a field after one step
   logic [8:0] sec_step;
   logic [8:0] min_step;

   //////////////////////////////////////////////////////////////////////
   // One step of a 00..59 field in BCD
   function automatic logic [8:0] step_field(
      input bcd_t units,
      input bcd_t tens,
      input bcd_t tens_max
   );
      logic [8:0] result;
      if (units != UNITS_MAX)
         result = {1'b0, tens, units + 4'd1};
      else if (tens != tens_max)
         result = {1'b0, tens + 4'd1, 4'd0};
      else
         result = {1'b1, 8'h00};
      return result;
   endfunction

   assign sec_step = step_field(units_q, tens_q, SEC_TENS_MAX);
   assign min_step = step_field(hundreds_q, thousands_q, MIN_TENS_MAX);

   //////////////////////////////////////////////////////////////////////
   // Time and run state
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         units_q     <= '0;
         tens_q      <= '0;
         hundreds_q  <= '0;
         thousands_q <= '0;
         run_q       <= 1'b0;
      end else if (reset) begin
         units_q     <= '0;
         tens_q      <= '0;
         hundreds_q  <= '0;
         thousands_q <= '0;
         run_q       <= 1'b0;
      end else begin
         if (pause)
            run_q <= ~run_q;

         if (adj) begin
            // Adjust: the selected field runs alone at 2 Hz
            if (tick_2hz) begin
               if (sel == SEL_SECONDS)
                  {tens_q, units_q} <= sec_step[7:0];
               else
                  {thousands_q, hundreds_q} <= min_step[7:0];
            end
         end else if (run_q && tick_1hz) begin
            {tens_q, units_q} <= sec_step[7:0];
            // Seconds carry into minutes; the minute carry at 59:59 is the wrap
            if (sec_step[8])
               {thousands_q, hundreds_q} <= min_step[7:0];
         end
      end
   end

   assign time_o.units     = units_q;
   assign time_o.tens      = tens_q;
   assign time_o.hundreds  = hundreds_q;
   assign time_o.thousands = thousands_q;

endmodule

// ==== verilog/display_7_seg.sv ====
`timescale 1ns/1ns

module display_7_seg (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 tick_scan,
   input  logic                 blink,
   input  logic                 sel,
   input  logic                 adj,
   time_if.disp                 time_i,
   output stopwatch_pkg::seg_t  seg,
   output logic [3:0]           digit
);

   import stopwatch_pkg::*;

   logic [1:0] scan_idx;
   logic       scan_on;
   bcd_t       cur_digit;
   logic       field_is_min;
   logic       blank_now;

   //////////////////////////////////////////////////////////////////////
   // Scan index, 0 is units and 3 is minute tens
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         // First tick lands on units
         scan_idx <= 2'd3;
         scan_on  <= 1'b0;
      end else if (tick_scan) begin
         scan_idx <= scan_idx + 2'd1;
         scan_on  <= 1'b1;
      end
   end

   // Digit under the scan
   always_comb begin
      case (scan_idx)
         2'd0:    cur_digit = time_i.units;
         2'd1:    cur_digit = time_i.tens;
         2'd2:    cur_digit = time_i.hundreds;
         default: cur_digit = time_i.thousands;
      endcase
   end

   // Upper two positions are the minutes
   assign field_is_min = scan_idx[1];

   // Blank the field under adjustment during the blink-high half
   assign blank_now = adj && blink && (field_is_min == (sel == SEL_MINUTES));

   //////////////////////////////////////////////////////////////////////
   // Registered drive to the display pins
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         seg   <= SEG_BLANK;
         digit <= 4'hf;
      end else if (scan_on) begin
         digit <= ~(4'b0001 << scan_idx);
         seg   <= blank_now ? SEG_BLANK : bcd_to_seg(cur_digit);
      end
   end

endmodule

// ==== verilog/stopwatch.sv ====
`timescale 1ns/1ns

module stopwatch #(
   parameter int DIV_1HZ         = 100_000_000,
   parameter int DIV_SCAN        = 100_000,
   parameter int DEBOUNCE_CYCLES = 1_000_000
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                pause,
   input  logic                reset,
   input  logic [1:0]          sw,
   output stopwatch_pkg::seg_t seg,
   output logic [3:0]          digit
);

   // Ticks from the prescaler
   logic tick_1hz;
   logic tick_2hz;
   logic tick_scan;
   logic blink;

   // Cleaned buttons and switches
   logic rst_press;
   logic rst_state;
   logic pause_press;
   logic sel_state;
   logic adj_state;

   time_if time_bus ();

   //////////////////////////////////////////////////////////////////////
   // Timing
   tick_gen #(
      .DIV_1HZ  (DIV_1HZ),
      .DIV_SCAN (DIV_SCAN)
   ) i_tick_gen (
      .clk       (clk),
      .rst_n     (rst_n),
      .restart   (rst_press),
      .tick_1hz  (tick_1hz),
      .tick_2hz  (tick_2hz),
      .tick_scan (tick_scan),
      .blink     (blink)
   );

   //////////////////////////////////////////////////////////////////////
   // Inputs, sw[0] is sel and sw[1] is adj
   debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) i_deb_reset (
      .clk(clk), .rst_n(rst_n), .switch_input(reset),
      .state(rst_state), .press(rst_press)
   );

   debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) i_deb_pause (
      .clk(clk), .rst_n(rst_n), .switch_input(pause),
      .state(), .press(pause_press)
   );

   debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) i_deb_sel (
      .clk(clk), .rst_n(rst_n), .switch_input(sw[0]),
      .state(sel_state), .press()
   );

   debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) i_deb_adj (
      .clk(clk), .rst_n(rst_n), .switch_input(sw[1]),
      .state(adj_state), .press()
   );

   //////////////////////////////////////////////////////////////////////
   // Time keeping and display
   timer_seq i_timer_seq (
      .clk      (clk),
      .rst_n    (rst_n),
      .tick_1hz (tick_1hz),
      .tick_2hz (tick_2hz),
      .reset    (rst_press | rst_state),
      .pause    (pause_press),
      .sel      (sel_state),
      .adj      (adj_state),
      .time_o   (time_bus.timer)
   );

   display_7_seg i_display (
      .clk       (clk),
      .rst_n     (rst_n),
      .tick_scan (tick_scan),
      .blink     (blink),
      .sel       (sel_state),
      .adj       (adj_state),
      .time_i    (time_bus.disp),
      .seg       (seg),
      .digit     (digit)
   );

endmodule

// ==== dv/stopwatch_assertions.sv ====
`timescale 1ns/1ns

module stopwatch_assertions (
   input logic                clk,
   input logic                rst_n,
   input logic                tick_1hz,
   input logic                tick_2hz,
   input stopwatch_pkg::bcd_t units,
   input stopwatch_pkg::bcd_t tens,
   input stopwatch_pkg::bcd_t hundreds,
   input stopwatch_pkg::bcd_t thousands
);

   import stopwatch_pkg::*;

   // Every digit within its BCD limit
   a_units_range: assert property (@(posedge clk) disable iff (!rst_n)
      units <= UNITS_MAX) else $error("Seconds units above 9");
   a_tens_range: assert property (@(posedge clk) disable iff (!rst_n)
      tens <= SEC_TENS_MAX) else $error("Seconds tens above 5");
   a_hundreds_range: assert property (@(posedge clk) disable iff (!rst_n)
      hundreds <= UNITS_MAX) else $error("Minutes units above 9");
   a_thousands_range: assert property (@(posedge clk) disable iff (!rst_n)
      thousands <= MIN_TENS_MAX) else $error("Minutes tens above 5");

   // Ticks are single-cycle strobes
   a_tick_2hz_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      tick_2hz |=> !tick_2hz) else $error("tick_2hz high for more than one cycle");
   a_tick_1hz_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      tick_1hz |=> !tick_1hz) else $error("tick_1hz high for more than one cycle");

   // A full second always closes a half second
   a_tick_aligned: assert property (@(posedge clk) disable iff (!rst_n)
      tick_1hz |-> tick_2hz) else $error("tick_1hz without tick_2hz");

endmodule

bind timer_seq stopwatch_assertions i_timer_assertions (
   .clk       (clk),
   .rst_n     (rst_n),
   .tick_1hz  (tick_1hz),
   .tick_2hz  (tick_2hz),
   .units     (units_q),
   .tens      (tens_q),
   .hundreds  (hundreds_q),
   .thousands (thousands_q)
);

// ==== dv/stopwatch_tb.sv ====
`timescale 1ns/1ns

module stopwatch_tb;

   import stopwatch_pkg::*;

   localparam int    DIV_1HZ         = 400;
   localparam int    DIV_SCAN        = 10;
   localparam int    DEBOUNCE_CYCLES = 8;
   localparam int    QUARTER         = DIV_1HZ / 4;
   localparam string CASES_FILE      = "dv/stopwatch_cases.txt";

   logic        clk = 1'b0;
   logic        rst_n;
   logic        pause;
   logic        reset;
   logic [1:0]  sw;
   seg_t        seg;
   logic [3:0]  digit;

   int          cyc = 0;
   int          cycle_limit = 0;
   int          cursor;
   logic [31:0] lfsr;
   logic        adj_on;
   logic        sel_sec;
   // Latest seg seen per position, 0 is seconds units
   seg_t        scan_seg [4];

   stopwatch #(
      .DIV_1HZ         (DIV_1HZ),
      .DIV_SCAN        (DIV_SCAN),
      .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
   ) i_stopwatch (
      .clk   (clk),
      .rst_n (rst_n),
      .pause (pause),
      .reset (reset),
      .sw    (sw),
      .seg   (seg),
      .digit (digit)
   );

   always #4 clk = ~clk;

   //////////////////////////////////////////////////////////////////////
   // Checks and helpers
   task automatic abort_run();
      $display("** FAIL **");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic check_seg(input int pos, input seg_t got, input seg_t expected);
      if (got !== expected) begin
         $display("FAILED seg at digit %0d: got 0x%h, expected 0x%h", pos, got, expected);
         abort_run();
      end
   endtask

   task automatic check_digit_scan(input logic [3:0] value);
      if (value !== 4'hf && $countones(~value) != 1) begin
         $display("FAILED digit: got 0x%h, expected one-hot-low", value);
         abort_run();
      end
   endtask

   // Lit segments in gfedcba order, inverted for the common anode
   function automatic seg_t expected_seg(input int value);
      logic [6:0] lit;
      case (value)
         0:       lit = 7'b0111111;
         1:       lit = 7'b0000110;
         2:       lit = 7'b1011011;
         3:       lit = 7'b1001111;
         4:       lit = 7'b1100110;
         5:       lit = 7'b1101101;
         6:       lit = 7'b1111101;
         7:       lit = 7'b0000111;
         8:       lit = 7'b1111111;
         9:       lit = 7'b1101111;
         default: lit = 7'b0000000;
      endcase
      return ~lit;
   endfunction

   function automatic logic random_bit();
      logic out;
      out  = lfsr[0];
      lfsr = lfsr >> 1;
      if (out)
         lfsr = lfsr ^ 32'h8020_0003;
      return out;
   endfunction

   task automatic check_display(input int mm, input int ss, input logic blank_sec,
                                input logic blank_min);
      int   value [4];
      seg_t expected;
      value = '{ss % 10, ss / 10, mm % 10, mm / 10};
      for (int i = 0; i < 4; i++) begin
         expected = expected_seg(value[i]);
         if ((i < 2) ? blank_sec : blank_min)
            expected = SEG_BLANK;
         check_seg(i, scan_seg[i], expected);
      end
   endtask

   task automatic wait_to(input int target);
      while (cyc < target)
         @(negedge clk);
   endtask

   task automatic press_button(input logic on_reset);
      if (on_reset)
         reset = 1'b1;
      else
         pause = 1'b1;
      repeat (2 * DEBOUNCE_CYCLES) @(negedge clk);
      reset = 1'b0;
      pause = 1'b0;
   endtask

   // Bounce shorter than the debounce window on one button
   task automatic glitch_burst();
      logic on_reset;
      logic level;
      int   len;
      on_reset = random_bit();
      len = 0;
      repeat (3) len = 2 * len + int'(random_bit());
      if (len == 0)
         len = 1;
      if (len >= DEBOUNCE_CYCLES)
         len = DEBOUNCE_CYCLES - 1;
      for (int i = 0; i < len; i++) begin
         level = (i == 0) ? 1'b1 : random_bit();
         if (on_reset)
            reset = level;
         else
            pause = level;
         @(negedge clk);
      end
      reset = 1'b0;
      pause = 1'b0;
   endtask

   // Whole seconds from the cursor, blink is high half way through each
   task automatic run_seconds(input int secs, input int mm, input int ss);
      for (int i = 0; i < secs; i++) begin
         wait_to(cursor + QUARTER + QUARTER / 2);
         glitch_burst();
         wait_to(cursor + 2 * QUARTER);
         if (adj_on)
            check_display(mm, ss, sel_sec, !sel_sec);
         cursor = cursor + DIV_1HZ;
      end
      wait_to(cursor);
      check_display(mm, ss, 1'b0, 1'b0);
   endtask

   task automatic apply_case(input logic [127:0] op, input int secs, input int mm,
                             input int ss);
      wait_to(cursor);
      if (op == "reset") begin
         // Restart aligns the ticks, so checks sit a quarter second off them
         cursor = cyc + QUARTER;
         press_button(1'b1);
      end else if (op == "pause") begin
         press_button(1'b0);
      end else if (op == "adjust-seconds" || op == "adjust-minutes") begin
         adj_on  = 1'b1;
         sel_sec = (op == "adjust-seconds");
         sw      = {1'b1, sel_sec ? SEL_SECONDS : SEL_MINUTES};
      end else if (op == "run-off") begin
         adj_on = 1'b0;
         sw     = 2'b00;
      end else if (op != "wait") begin
         $display("Unknown operation in the case file: %0s", op);
         abort_run();
      end
      run_seconds(secs, mm, ss);
   endtask

   task automatic read_case(input int fd, output logic found, output logic [127:0] op,
                            output int secs, output int mm, output int ss);
      string line;
      int    count;
      found = 1'b0;
      while (!found && !$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() > 0 && line[0] != "#") begin
            count = $sscanf(line, "%s %d %d %d", op, secs, mm, ss);
            if (count == 4) begin
               found = 1'b1;
            end else if (count > 0) begin
               $display("Bad case line, it needs an operation and three numbers: %s", line);
               abort_run();
            end
         end
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Display monitor and watchdog
   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (cycle_limit > 0 && cyc >= cycle_limit) begin
         $display("Timeout: the run went past %0d cycles", cycle_limit);
         abort_run();
      end
      if (rst_n) begin
         check_digit_scan(digit);
         case (digit)
            4'b1110: scan_seg[0] <= seg;
            4'b1101: scan_seg[1] <= seg;
            4'b1011: scan_seg[2] <= seg;
            4'b0111: scan_seg[3] <= seg;
            default: ;
         endcase
      end
   end

   initial begin
      int           fd;
      int           total;
      int           secs;
      int           mm;
      int           ss;
      logic         found;
      logic [127:0] op;
      rst_n   = 1'b0;
      pause   = 1'b0;
      reset   = 1'b0;
      sw      = 2'b00;
      adj_on  = 1'b0;
      sel_sec = 1'b0;
      lfsr    = 32'hef58_6176;

      // First pass sizes the watchdog
      total = 0;
      fd = $fopen(CASES_FILE, "r");
      if (fd == 0) begin
         $display("Cannot open the case file %s", CASES_FILE);
         abort_run();
      end
      read_case(fd, found, op, secs, mm, ss);
      while (found) begin
         total = total + secs;
         read_case(fd, found, op, secs, mm, ss);
      end
      $fclose(fd);
      cycle_limit = (total + 10) * DIV_1HZ;

      repeat (3) @(negedge clk);
      rst_n  = 1'b1;
      cursor = cyc;

      fd = $fopen(CASES_FILE, "r");
      read_case(fd, found, op, secs, mm, ss);
      while (found) begin
         apply_case(op, secs, mm, ss);
         read_case(fd, found, op, secs, mm, ss);
      end
      $fclose(fd);
      $display("** PASS **");
      $finish;
   end

endmodule

// ==== dv/stopwatch_cases.txt ====
# operation  seconds  expected_mm  expected_ss
# operations: reset pause adjust-seconds adjust-minutes run-off wait
reset 0 00 00
wait 2 00 00
pause 3 00 03
reset 1 00 00
pause 2 00 02
wait 57 00 59
wait 2 01 01
pause 1 01 01
wait 1 01 01
adjust-seconds 3 01 07
adjust-seconds 27 01 01
adjust-minutes 29 59 01
run-off 1 59 01
pause 58 59 59
wait 2 00 01
pause 1 00 01
wait 2 00 01
reset 2 00 00

// ==== build.f ====
verilog/stopwatch_pkg.sv
verilog/time_if.sv
verilog/tick_gen.sv
verilog/debouncer.sv
verilog/timer_seq.sv
verilog/display_7_seg.sv
verilog/stopwatch.sv
dv/stopwatch_assertions.sv
dv/stopwatch_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = stopwatch_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)
